// File: include/axi_link_settings.svh
`ifndef AXI_LINK_SETTINGS_SVH
`define AXI_LINK_SETTINGS_SVH

// Word and field widths
`define AXL_PHY_WIDTH       79
`define AXL_ID_WIDTH        4
`define AXL_ADDR_WIDTH      32
`define AXL_DATA_WIDTH      64
`define AXL_CRED_WIDTH      8
`define AXL_DELAY_WIDTH     16

// Receive buffer, sized to the credits the far side may hold
`define AXL_R_FIFO_DEPTH    8

// TX PHY word layout, bits 51 to 78 unused
`define AXL_TX_PUSH_BIT     0
`define AXL_TX_AR_LSB       1
`define AXL_TX_RCRED_BIT    50

// RX PHY word layout
`define AXL_RX_PUSH_BIT     0
`define AXL_RX_R_LSB        1
`define AXL_RX_ARCRED_BIT   72

`endif

// File: design/axi_link_pkg.sv
`default_nettype none

`include "axi_link_settings.svh"

package axi_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channel payloads, first field is the most significant

  // Read address, 49 bits
  typedef struct packed {
    logic [`AXL_ID_WIDTH-1:0]   id;
    logic [2:0]                 size;
    logic [7:0]                 len;
    logic [1:0]                 burst;
    logic [`AXL_ADDR_WIDTH-1:0] addr;
  } ar_payload_t;

  // Read data, 71 bits
  typedef struct packed {
    logic [`AXL_ID_WIDTH-1:0]   id;
    logic [`AXL_DATA_WIDTH-1:0] data;
    logic                       last;
    logic [1:0]                 resp;
  } r_payload_t;

endpackage

`default_nettype wire

// File: design/link_chan_if.sv
`default_nettype none
`timescale 1ns/10ps

// Strobes and payloads between the channel logic and the PHY packer
interface link_chan_if;

  logic                      ar_push;
  axi_link_pkg::ar_payload_t ar_data;
  logic                      ar_credit;
  logic                      r_push;
  axi_link_pkg::r_payload_t  r_data;
  logic                      r_credit;

  modport ar_side (
    output ar_push,
    output ar_data,
    input  ar_credit
  );

  modport r_side (
    input  r_push,
    input  r_data,
    output r_credit
  );

  modport phy_side (
    input  ar_push,
    input  ar_data,
    input  r_credit,
    output ar_credit,
    output r_push,
    output r_data
  );

  // Observation only
  modport mon (
    input ar_push,
    input ar_data,
    input ar_credit,
    input r_push,
    input r_data,
    input r_credit
  );

endinterface

`default_nettype wire

// File: design/link_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module link_ctrl (
  input  logic                        clk_wr,
  input  logic                        rst_n,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [`AXL_DELAY_WIDTH-1:0] delay_value,
  input  logic [`AXL_CRED_WIDTH-1:0]  init_ar_credit_cfg,
  output logic                        link_up,
  output logic [`AXL_CRED_WIDTH-1:0]  init_ar_credit
);

  logic                        online;
  logic                        online_q;
  logic [`AXL_DELAY_WIDTH-1:0] delay_q;
  logic [`AXL_DELAY_WIDTH-1:0] delay_cnt;

  assign online = tx_online && rx_online;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration capture

  // Frozen once the link is up
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      delay_q        <= '0;
      init_ar_credit <= '0;
    end else if (!link_up) begin
      delay_q        <= delay_value;
      init_ar_credit <= init_ar_credit_cfg;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Online delay

  // Count starts the edge after both sides are seen online, so link_up
  // lands delay+1 edges after that first sample
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      online_q  <= 1'b0;
      delay_cnt <= '0;
      link_up   <= 1'b0;
    end else if (!online) begin
      // Either side dropping takes the link down at once
      online_q  <= 1'b0;
      delay_cnt <= '0;
      link_up   <= 1'b0;
    end else begin
      online_q <= 1'b1;
      if (online_q && !link_up) begin
        if (delay_cnt == delay_q) begin
          link_up <= 1'b1;
        end else begin
          delay_cnt <= delay_cnt + `AXL_DELAY_WIDTH'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ar_transmit.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module ar_transmit (
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       link_up,
  input  logic [`AXL_CRED_WIDTH-1:0] init_ar_credit,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  axi_link_pkg::ar_payload_t  ar_req,
  link_chan_if.ar_side               chan
);

  localparam logic [`AXL_CRED_WIDTH-1:0] CRED_ONE = `AXL_CRED_WIDTH'(1);

  logic                       loaded;
  logic [`AXL_CRED_WIDTH-1:0] credit_q;
  logic [`AXL_CRED_WIDTH-1:0] credit_cur;
  logic                       handshake;

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter

  // First cycle of link up runs on the captured initial credit
  assign credit_cur = loaded ? credit_q : init_ar_credit;

  assign ar_ready  = link_up && (credit_cur != '0);
  assign handshake = ar_valid && ar_ready;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      loaded   <= 1'b0;
      credit_q <= '0;
    end else if (!link_up) begin
      loaded   <= 1'b0;
      credit_q <= '0;
    end else begin
      loaded <= 1'b1;
      // Send and return in one edge cancel out
      case ({chan.ar_credit, handshake})
        2'b10:   credit_q <= credit_cur + CRED_ONE;
        2'b01:   credit_q <= credit_cur - CRED_ONE;
        default: credit_q <= credit_cur;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Push to the link

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      chan.ar_push <= 1'b0;
    end else begin
      chan.ar_push <= handshake;
    end
  end

  // Payload only moves on a handshake
  always_ff @(posedge clk_wr) begin
    if (handshake) begin
      chan.ar_data <= ar_req;
    end
  end

endmodule

`default_nettype wire

// File: design/r_receive.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module r_receive (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  input  logic                     link_up,
  output logic                     r_valid,
  input  logic                     r_ready,
  output axi_link_pkg::r_payload_t r_beat,
  link_chan_if.r_side              chan
);

  localparam int PTR_W = $clog2(`AXL_R_FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(`AXL_R_FIFO_DEPTH);
  localparam logic [PTR_W:0] COUNT_ONE  = (PTR_W + 1)'(1);

  axi_link_pkg::r_payload_t mem [`AXL_R_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             wr_en;
  logic             pop;

  assign full = (count == FULL_COUNT);

  // Pushes beyond the granted credits are lost
  assign wr_en = link_up && chan.r_push && !full;

  ////////////////////////////////////////////////////////////////////////////
  // User side

  assign r_valid = (count != '0);
  assign r_beat  = mem[rd_ptr];
  assign pop     = r_valid && r_ready;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO control

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (!link_up) begin
      // Flush on link down
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({wr_en, pop})
        2'b10:   count <= count + COUNT_ONE;
        2'b01:   count <= count - COUNT_ONE;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= chan.r_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit return

  // One strobe per beat taken by the user
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      chan.r_credit <= 1'b0;
    end else begin
      chan.r_credit <= pop;
    end
  end

endmodule

`default_nettype wire

// File: design/phy_pack.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module phy_pack (
  input  logic                     clk_wr,
  input  logic                     rst_n,
  output logic [`AXL_PHY_WIDTH-1:0] tx_phy,
  input  logic [`AXL_PHY_WIDTH-1:0] rx_phy,
  link_chan_if.phy_side            chan
);

  localparam int AR_W = $bits(axi_link_pkg::ar_payload_t);
  localparam int R_W  = $bits(axi_link_pkg::r_payload_t);

  logic [`AXL_PHY_WIDTH-1:0] tx_word;

  ////////////////////////////////////////////////////////////////////////////
  // TX word

  always_comb begin
    tx_word                         = '0;
    tx_word[`AXL_TX_PUSH_BIT]       = chan.ar_push;
    // Payload field stays zero between pushes
    tx_word[`AXL_TX_AR_LSB +: AR_W] = chan.ar_push ? chan.ar_data : '0;
    tx_word[`AXL_TX_RCRED_BIT]      = chan.r_credit;
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RX word

  // Straight decode, the receive FIFO does the registering
  assign chan.r_push    = rx_phy[`AXL_RX_PUSH_BIT];
  assign chan.r_data    = rx_phy[`AXL_RX_R_LSB +: R_W];
  assign chan.ar_credit = rx_phy[`AXL_RX_ARCRED_BIT];

endmodule

`default_nettype wire

// File: design/axi_link_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module axi_link_top (
  input  logic                        clk_wr,
  input  logic                        rst_n,

  // Link control and configuration
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [`AXL_DELAY_WIDTH-1:0] delay_value,
  input  logic [`AXL_CRED_WIDTH-1:0]  init_ar_credit,

  // PHY
  output logic [`AXL_PHY_WIDTH-1:0]   tx_phy,
  input  logic [`AXL_PHY_WIDTH-1:0]   rx_phy,

  // AR channel
  input  logic [`AXL_ID_WIDTH-1:0]    user_arid,
  input  logic [2:0]                  user_arsize,
  input  logic [7:0]                  user_arlen,
  input  logic [1:0]                  user_arburst,
  input  logic [`AXL_ADDR_WIDTH-1:0]  user_araddr,
  input  logic                        user_arvalid,
  output logic                        user_arready,

  // R channel
  output logic [`AXL_ID_WIDTH-1:0]    user_rid,
  output logic [`AXL_DATA_WIDTH-1:0]  user_rdata,
  output logic                        user_rlast,
  output logic [1:0]                  user_rresp,
  output logic                        user_rvalid,
  input  logic                        user_rready
);

  logic                       link_up;
  logic [`AXL_CRED_WIDTH-1:0] cfg_ar_credit;
  axi_link_pkg::ar_payload_t  ar_req;
  axi_link_pkg::r_payload_t   r_beat;

  link_chan_if chan_i ();

  ////////////////////////////////////////////////////////////////////////////
  // User payload mapping

  assign ar_req.id    = user_arid;
  assign ar_req.size  = user_arsize;
  assign ar_req.len   = user_arlen;
  assign ar_req.burst = user_arburst;
  assign ar_req.addr  = user_araddr;

  assign user_rid   = r_beat.id;
  assign user_rdata = r_beat.data;
  assign user_rlast = r_beat.last;
  assign user_rresp = r_beat.resp;

  ////////////////////////////////////////////////////////////////////////////
  // Instances

  link_ctrl link_ctrl_i (
    .clk_wr             (clk_wr),
    .rst_n              (rst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .delay_value        (delay_value),
    .init_ar_credit_cfg (init_ar_credit),
    .link_up            (link_up),
    .init_ar_credit     (cfg_ar_credit)
  );

  ar_transmit ar_transmit_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .link_up        (link_up),
    .init_ar_credit (cfg_ar_credit),
    .ar_valid       (user_arvalid),
    .ar_ready       (user_arready),
    .ar_req         (ar_req),
    .chan           (chan_i.ar_side)
  );

  r_receive r_receive_i (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .link_up (link_up),
    .r_valid (user_rvalid),
    .r_ready (user_rready),
    .r_beat  (r_beat),
    .chan    (chan_i.r_side)
  );

  phy_pack phy_pack_i (
    .clk_wr (clk_wr),
    .rst_n  (rst_n),
    .tx_phy (tx_phy),
    .rx_phy (rx_phy),
    .chan   (chan_i.phy_side)
  );

endmodule

`default_nettype wire

// File: verif/axi_link_properties.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module axi_link_properties (
  input logic                       clk_wr,
  input logic                       rst_n,
  input logic                       link_up,
  input logic                       user_arvalid,
  input logic                       user_arready,
  input logic                       user_rvalid,
  input logic                       user_rready,
  input logic [`AXL_ID_WIDTH-1:0]   user_rid,
  input logic [`AXL_DATA_WIDTH-1:0] user_rdata,
  input logic                       user_rlast,
  input logic [1:0]                 user_rresp,
  input logic [`AXL_PHY_WIDTH-1:0]  tx_phy,
  input logic [`AXL_PHY_WIDTH-1:0]  rx_phy
);

  logic                                   rx_push;
  logic [$clog2(`AXL_R_FIFO_DEPTH):0]     held;

  assign rx_push = rx_phy[`AXL_RX_PUSH_BIT];

  // Beats waiting in the receive FIFO as seen from the ports
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      held <= '0;
    end else if (!link_up) begin
      held <= '0;
    end else if (rx_push && !(user_rvalid && user_rready)) begin
      held <= held + 1'b1;
    end else if (!rx_push && user_rvalid && user_rready) begin
      held <= held - 1'b1;
    end
  end

  // AR handshake reaches the PHY word two edges later
  ar_push_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_arvalid && user_arready |-> ##2 tx_phy[`AXL_TX_PUSH_BIT])
    else $error("AR handshake without push bit on tx_phy two cycles later");

  // Head beat holds under back-pressure while the link stays up
  r_hold_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_rvalid && !user_rready && link_up |=> user_rvalid && $stable(user_rid)
      && $stable(user_rdata) && $stable(user_rlast) && $stable(user_rresp))
    else $error("R beat changed while user_rready was low");

  r_credit_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_rvalid && user_rready |-> ##2 tx_phy[`AXL_TX_RCRED_BIT])
    else $error("R pop without credit bit on tx_phy two cycles later");

  // Far side must not push beyond its credits
  r_overflow_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    link_up && rx_push |-> held != `AXL_R_FIFO_DEPTH)
    else $error("R push while the receive FIFO was full");

endmodule

bind axi_link_top axi_link_properties props_i (
  .clk_wr       (clk_wr),
  .rst_n        (rst_n),
  .link_up      (link_up),
  .user_arvalid (user_arvalid),
  .user_arready (user_arready),
  .user_rvalid  (user_rvalid),
  .user_rready  (user_rready),
  .user_rid     (user_rid),
  .user_rdata   (user_rdata),
  .user_rlast   (user_rlast),
  .user_rresp   (user_rresp),
  .tx_phy       (tx_phy),
  .rx_phy       (rx_phy)
);

`default_nettype wire

// File: verif/axi_link_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "axi_link_settings.svh"

module axi_link_tb;

  localparam int RESET_CYCLES = 16;
  localparam int LINK_DELAY   = 5;
  localparam int N_AR         = 4;
  localparam int N_BEATS      = `AXL_R_FIFO_DEPTH;
  localparam int AR_W         = $bits(axi_link_pkg::ar_payload_t);
  localparam int R_W          = $bits(axi_link_pkg::r_payload_t);
  // Sum of the test lengths, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + (LINK_DELAY + 4) + 3 * N_AR
    + (2 * LINK_DELAY + 16) + 16 * N_BEATS + 10);

  logic                        clk_wr;
  logic                        rst_n;
  logic                        tx_online;
  logic                        rx_online;
  logic [`AXL_DELAY_WIDTH-1:0] delay_value;
  logic [`AXL_CRED_WIDTH-1:0]  init_ar_credit;
  logic [`AXL_PHY_WIDTH-1:0]   tx_phy;
  logic [`AXL_PHY_WIDTH-1:0]   rx_phy;
  axi_link_pkg::ar_payload_t   ar_drv;
  logic                        user_arvalid;
  logic                        user_arready;
  axi_link_pkg::r_payload_t    r_seen;
  logic                        user_rvalid;
  logic                        user_rready;
  axi_link_pkg::ar_payload_t   tx_ar;

  int          value_errors;
  int          other_errors;
  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'h1fca_877c;

  assign tx_ar = tx_phy[`AXL_TX_AR_LSB +: AR_W];

  axi_link_top dut_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_value    (delay_value),
    .init_ar_credit (init_ar_credit),
    .tx_phy         (tx_phy),
    .rx_phy         (rx_phy),
    .user_arid      (ar_drv.id),
    .user_arsize    (ar_drv.size),
    .user_arlen     (ar_drv.len),
    .user_arburst   (ar_drv.burst),
    .user_araddr    (ar_drv.addr),
    .user_arvalid   (user_arvalid),
    .user_arready   (user_arready),
    .user_rid       (r_seen.id),
    .user_rdata     (r_seen.data),
    .user_rlast     (r_seen.last),
    .user_rresp     (r_seen.resp),
    .user_rvalid    (user_rvalid),
    .user_rready    (user_rready)
  );

  always #10 clk_wr = ~clk_wr;

  always @(posedge clk_wr) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and compare tasks

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function axi_link_pkg::ar_payload_t random_ar();
    axi_link_pkg::ar_payload_t p;
    logic [31:0] a;
    a = lcg_next();
    p.id    = a[3:0];
    p.size  = a[6:4];
    p.len   = a[14:7];
    p.burst = a[16:15];
    p.addr  = lcg_next();
    return p;
  endfunction

  function axi_link_pkg::r_payload_t random_r();
    axi_link_pkg::r_payload_t p;
    logic [31:0] a;
    a = lcg_next();
    p.id   = a[31:28];
    p.last = a[20];
    p.resp = a[25:24];
    p.data = {lcg_next(), lcg_next()};
    return p;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_ar(input string name, input axi_link_pkg::ar_payload_t got,
                          input axi_link_pkg::ar_payload_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_r(input string name, input axi_link_pkg::r_payload_t got,
                         input axi_link_pkg::r_payload_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_wr);
    @(negedge clk_wr);
  endtask

  // One handshake, push bit visible at the second edge after it
  task automatic send_ar(input axi_link_pkg::ar_payload_t req);
    check_bit("user_arready", user_arready, 1'b1);
    ar_drv       = req;
    user_arvalid = 1'b1;
    next_cycle();
    user_arvalid = 1'b0;
    ar_drv       = '0;
    check_bit("tx_phy push", tx_phy[`AXL_TX_PUSH_BIT], 1'b0);
    next_cycle();
    check_bit("tx_phy push", tx_phy[`AXL_TX_PUSH_BIT], 1'b1);
    check_ar("tx_phy ar", tx_ar, req);
    next_cycle();
    check_bit("tx_phy push", tx_phy[`AXL_TX_PUSH_BIT], 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_link();
    check_bit("user_arready", user_arready, 1'b0);
    check_bit("user_rvalid", user_rvalid, 1'b0);
    check_bit("tx_phy push", tx_phy[`AXL_TX_PUSH_BIT], 1'b0);
    check_bit("tx_phy r credit", tx_phy[`AXL_TX_RCRED_BIT], 1'b0);
    check_bit("tx_phy spare", |tx_phy[`AXL_PHY_WIDTH-1:`AXL_TX_RCRED_BIT+1], 1'b0);
    check_ar("tx_phy ar", tx_ar, '0);
    delay_value    = LINK_DELAY;
    init_ar_credit = 8;
    next_cycle();
    tx_online = 1'b1;
    rx_online = 1'b1;
    // Step 0 is the first edge that samples both sides online
    for (int k = 0; k <= LINK_DELAY + 1; k++) begin
      next_cycle();
      check_bit("user_arready", user_arready, k == LINK_DELAY + 1);
    end
  endtask

  task automatic test_ar_send();
    for (int i = 0; i < N_AR; i++) begin
      send_ar(random_ar());
    end
  endtask

  task automatic test_ar_credit();
    int n;
    tx_online = 1'b0;
    next_cycle();
    check_bit("user_arready", user_arready, 1'b0);
    init_ar_credit = 2;
    next_cycle();
    tx_online = 1'b1;
    n = 0;
    while (!user_arready && n < LINK_DELAY + 4) begin
      next_cycle();
      n++;
    end
    if (!user_arready) begin
      other_errors++;
      $display("Link did not come back up after reconnect");
    end
    send_ar(random_ar());
    send_ar(random_ar());
    check_bit("user_arready", user_arready, 1'b0);
    // One returned credit from the far side
    rx_phy[`AXL_RX_ARCRED_BIT] = 1'b1;
    next_cycle();
    rx_phy = '0;
    check_bit("user_arready", user_arready, 1'b1);
  endtask

  // Ordering, hold under back-pressure and the credit strobe per pop
  task automatic test_r_stream();
    axi_link_pkg::r_payload_t expect_q[$];
    axi_link_pkg::r_payload_t next_beat;
    logic [31:0] rnd;
    logic        push_now;
    logic        pop_now;
    logic        pop_d1;
    logic        hold;
    int          pushed;
    int          pops;
    int          credits;
    push_now = 1'b0;
    pop_now  = 1'b0;
    pop_d1   = 1'b0;
    hold     = 1'b0;
    pushed   = 0;
    pops     = 0;
    credits  = 0;
    do begin
      // Model catches up with the edge just passed
      if (pop_now) begin
        void'(expect_q.pop_front());
      end
      if (push_now) begin
        expect_q.push_back(next_beat);
      end
      check_bit("tx_phy r credit", tx_phy[`AXL_TX_RCRED_BIT], pop_d1);
      if (tx_phy[`AXL_TX_RCRED_BIT]) begin
        credits++;
      end
      if (hold && !user_rvalid) begin
        other_errors++;
        $display("user_rvalid dropped while user_rready was low");
      end
      check_bit("user_rvalid", user_rvalid, expect_q.size() != 0);
      if (user_rvalid && expect_q.size() != 0) begin
        check_r("user_r", r_seen, expect_q[0]);
      end
      rnd         = lcg_next();
      user_rready = rnd[31];
      pop_d1      = pop_now;
      pop_now     = user_rvalid && user_rready;
      hold        = user_rvalid && !user_rready;
      pops        = pops + int'(pop_now);
      push_now    = (pushed < N_BEATS);
      rx_phy      = '0;
      if (push_now) begin
        next_beat = random_r();
        rx_phy[`AXL_RX_PUSH_BIT]      = 1'b1;
        rx_phy[`AXL_RX_R_LSB +: R_W]  = next_beat;
        pushed++;
      end
      next_cycle();
    end while (push_now || pop_now || pop_d1 || expect_q.size() != 0);
    user_rready = 1'b0;
    if (pops != N_BEATS || credits != pops) begin
      other_errors++;
      $display("Saw %0d R credits for %0d pops of %0d beats", credits, pops, N_BEATS);
    end
  endtask

  task automatic test_link_drop();
    int n;
    for (int i = 0; i < 2; i++) begin
      rx_phy = '0;
      rx_phy[`AXL_RX_PUSH_BIT]     = 1'b1;
      rx_phy[`AXL_RX_R_LSB +: R_W] = random_r();
      next_cycle();
    end
    rx_phy = '0;
    check_bit("user_rvalid", user_rvalid, 1'b1);
    check_bit("user_arready", user_arready, 1'b1);
    rx_online = 1'b0;
    next_cycle();
    check_bit("user_arready", user_arready, 1'b0);
    n = 0;
    while (user_rvalid && n < 4) begin
      next_cycle();
      n++;
    end
    if (user_rvalid) begin
      other_errors++;
      $display("Receive FIFO still holds data after the link dropped");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    clk_wr         = 1'b0;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    delay_value    = '0;
    init_ar_credit = '0;
    rx_phy         = '0;
    ar_drv         = '0;
    user_arvalid   = 1'b0;
    user_rready    = 1'b0;
    value_errors   = 0;
    other_errors   = 0;
    repeat (RESET_CYCLES) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_n = 1'b1;
    test_reset_link();
    test_ar_send();
    test_ar_credit();
    test_r_stream();
    test_link_drop();
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_link.f
+incdir+include
design/axi_link_pkg.sv
design/link_chan_if.sv
design/link_ctrl.sv
design/ar_transmit.sv
design/r_receive.sv
design/phy_pack.sv
design/axi_link_top.sv
verif/axi_link_properties.sv
verif/axi_link_tb.sv
